/* traffic_settings.svh */
// Traffic driver settings
`ifndef TRAFFIC_SETTINGS_SVH
`define TRAFFIC_SETTINGS_SVH

// data path
`define TD_LANES      4
`define TD_BURST_LEN  2

// address range walked by one pass
`define TD_COL_MAX    6
`define TD_COL_STEP   2
`define TD_ROW_MAX    1
`define TD_BANK_MAX   1

// lane n starts from base + n * step
`define TD_SEED_BASE  1
`define TD_SEED_STEP  10

`define TD_PIPE_DEPTH 3

`endif

/* mem_local_pkg.sv */
// Memory controller local port types
`include "traffic_settings.svh"

package mem_local_pkg;

  // one data word, eight bits per lane
  typedef logic [`TD_LANES*8-1:0] local_data_t;

  // one flag per byte lane
  typedef logic [`TD_LANES-1:0] lane_mask_t;

  // command and address presented with each request
  typedef struct packed {
    logic        write_req;
    logic        read_req;
    logic        burstbegin;
    logic [5:0]  size;
    logic [2:0]  bank;
    logic [13:0] row;
    logic [9:0]  col;
  } local_cmd_t;

  // read return, no back-pressure
  typedef struct packed {
    logic        valid;
    local_data_t data;
  } local_rdata_t;

endpackage

/* traffic_pkg.sv */
// Traffic driver internal types
package traffic_pkg;

  typedef enum logic [2:0] {
    IDLE        = 3'd0,
    WRITE_FIRST = 3'd1,
    WRITE_BEAT  = 3'd2,
    WRITE_LAST  = 3'd3,
    READ_CMD    = 3'd4,
    READ_DRAIN  = 3'd5,
    DONE        = 3'd6
  } ctrl_state_e;

  typedef struct packed {
    logic [2:0]  bank;
    logic [13:0] row;
    logic [9:0]  col;
  } mem_addr_t;

  // strobes from the FSM to the address and data generators
  typedef struct packed {
    logic addr_reset;
    logic addr_step;
    logic dgen_load;
    logic dgen_advance_wr;
  } gen_ctrl_t;

endpackage

/* lfsr8.sv */
// Byte lane LFSR generator
module lfsr8 (
  input  logic       clk,
  input  logic       reset_n,
  input  logic [7:0] seed,
  input  logic       load,
  input  logic       advance,
  output logic [7:0] data
);

  logic [7:0] seed_safe;
  logic       feedback;

  // an all-zero state would lock up the register
  assign seed_safe = (seed == 8'd0) ? 8'd1 : seed;

  // taps 8, 6, 5, 4
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= seed_safe;
    else if (load)
      data <= seed_safe;
    else if (advance)
      data <= {data[6:0], feedback};
  end

endmodule

/* data_gen.sv */
// Write and expected data generator
`include "traffic_settings.svh"

module data_gen (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      load,
  input  logic                      advance,
  output mem_local_pkg::local_data_t data
);

  import mem_local_pkg::*;

  localparam int LANES = $bits(local_data_t) / 8;

  // one independent sequence per byte lane, all stepping together
  for (genvar i = 0; i < LANES; i++)
  begin : g_lane
    localparam logic [7:0] LANE_SEED = 8'(`TD_SEED_BASE + i * `TD_SEED_STEP);

    lfsr8 u_lfsr (
      .clk     (clk),
      .reset_n (reset_n),
      .seed    (LANE_SEED),
      .load    (load),
      .advance (advance),
      .data    (data[8*i +: 8])
    );
  end

endmodule

/* addr_gen.sv */
// Sequential address counter
`include "traffic_settings.svh"

module addr_gen (
  input  logic                   clk,
  input  logic                   reset_n,
  input  logic                   addr_reset,
  input  logic                   addr_step,
  output traffic_pkg::mem_addr_t addr,
  output logic                   addr_last
);

  import traffic_pkg::*;

  localparam logic [9:0]  COL_MAX  = 10'(`TD_COL_MAX);
  localparam logic [9:0]  COL_STEP = 10'(`TD_COL_STEP);
  localparam logic [13:0] ROW_MAX  = 14'(`TD_ROW_MAX);
  localparam logic [2:0]  BANK_MAX = 3'(`TD_BANK_MAX);

  mem_addr_t addr_next;

  assign addr_last = (addr.col == COL_MAX) && (addr.row == ROW_MAX) && (addr.bank == BANK_MAX);

  // column innermost, then row, then bank
  always_comb
  begin
    addr_next = addr;
    if (addr.col >= COL_MAX)
    begin
      addr_next.col = '0;
      if (addr.row == ROW_MAX)
      begin
        addr_next.row  = '0;
        addr_next.bank = (addr.bank == BANK_MAX) ? 3'd0 : addr.bank + 3'd1;
      end
      else
        addr_next.row = addr.row + 14'd1;
    end
    else
      addr_next.col = addr.col + COL_STEP;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      addr <= '0;
    else if (addr_reset)
      addr <= '0;
    else if (addr_step)
      addr <= addr_next;
  end

endmodule

/* traffic_ctrl.sv */
// Write and read pass controller
`include "traffic_settings.svh"

module traffic_ctrl (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      local_ready,
  input  logic                      rdata_valid,
  input  logic                      addr_last,
  output mem_local_pkg::local_cmd_t cmd_req,
  output traffic_pkg::gen_ctrl_t    gen,
  output logic                      test_complete
);

  import mem_local_pkg::*;
  import traffic_pkg::*;

  // address fields are filled in at the top level
  localparam local_cmd_t CMD_BASE = '{size: 6'(`TD_BURST_LEN), default: '0};
  localparam logic [5:0] LAST_BEAT = 6'(`TD_BURST_LEN - 1);
  localparam logic [7:0] BURST_BEATS = 8'(`TD_BURST_LEN);

  ctrl_state_e state;
  ctrl_state_e state_next;
  logic        armed;
  logic [5:0]  beat_cnt;
  logic [7:0]  rd_outstanding;
  logic        wr_accept;
  logic        rd_accept;
  logic        last_beat;

  // ----------------------------------------------------------
  // request and strobe decode
  // ----------------------------------------------------------
  always_comb
  begin
    cmd_req            = CMD_BASE;
    cmd_req.write_req  = (state == WRITE_FIRST) || (state == WRITE_BEAT);
    cmd_req.read_req   = (state == READ_CMD);
    cmd_req.burstbegin = (state == WRITE_FIRST) || (state == READ_CMD);
  end

  assign wr_accept = cmd_req.write_req & local_ready;
  assign rd_accept = cmd_req.read_req & local_ready;
  assign last_beat = (beat_cnt == LAST_BEAT);

  // reload before each write pass and again before the read pass
  assign gen.addr_reset      = (state == IDLE) || (state == WRITE_LAST) || (state == DONE);
  assign gen.dgen_load       = gen.addr_reset;
  assign gen.addr_step       = (wr_accept & last_beat) | rd_accept;
  // write beats as accepted, read beats as they come back
  assign gen.dgen_advance_wr = wr_accept | rdata_valid;

  assign test_complete = (state == DONE);

  // ----------------------------------------------------------
  // next state
  // ----------------------------------------------------------
  always_comb
  begin
    state_next = state;
    case (state)
      IDLE:
        if (armed)
          state_next = WRITE_FIRST;
      WRITE_FIRST, WRITE_BEAT:
        if (wr_accept)
        begin
          if (!last_beat)
            state_next = WRITE_BEAT;
          else if (addr_last)
            state_next = WRITE_LAST;
          else
            state_next = WRITE_FIRST;
        end
      WRITE_LAST:
        state_next = READ_CMD;
      READ_CMD:
        if (rd_accept && addr_last)
          state_next = READ_DRAIN;
      READ_DRAIN:
        if (rd_outstanding == 8'd0)
          state_next = DONE;
      DONE:
        state_next = WRITE_FIRST;
      default:
        state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state    <= IDLE;
      armed    <= 1'b0;
      beat_cnt <= '0;
    end
    else
    begin
      state <= state_next;
      // idle spends one cycle on the reload
      if (state == IDLE)
        armed <= 1'b1;
      if (wr_accept)
        beat_cnt <= last_beat ? 6'd0 : beat_cnt + 6'd1;
    end
  end

  // beats requested but not yet returned
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      rd_outstanding <= '0;
    else if (rd_accept && rdata_valid)
      rd_outstanding <= rd_outstanding + BURST_BEATS - 8'd1;
    else if (rd_accept)
      rd_outstanding <= rd_outstanding + BURST_BEATS;
    else if (rdata_valid)
      rd_outstanding <= rd_outstanding - 8'd1;
  end

endmodule

/* data_checker.sv */
// Read data lane checker
`include "traffic_settings.svh"

module data_checker (
  input  logic                        clk,
  input  logic                        reset_n,
  input  mem_local_pkg::local_data_t  expected,
  input  mem_local_pkg::local_rdata_t rdata,
  output mem_local_pkg::lane_mask_t   pnf_per_byte,
  output logic                        pnf_persist
);

  import mem_local_pkg::*;

  // compare and hold take two of the stages
  localparam int OUT_STAGES = `TD_PIPE_DEPTH - 2;

  lane_mask_t lane_match;
  lane_mask_t compare_reg;
  lane_mask_t hold_reg;
  logic       valid_reg;
  logic       beat_seen;
  logic       fail_seen;
  lane_mask_t pnf_pipe [OUT_STAGES];
  logic       persist_pipe [OUT_STAGES];

  always_comb
  begin
    for (int i = 0; i < `TD_LANES; i++)
      lane_match[i] = (expected[8*i +: 8] == rdata.data[8*i +: 8]);
  end

  // ----------------------------------------------------------
  // compare and hold stages
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg <= '1;
      valid_reg   <= 1'b0;
      hold_reg    <= '1;
      beat_seen   <= 1'b0;
      fail_seen   <= 1'b0;
    end
    else
    begin
      compare_reg <= lane_match;
      valid_reg   <= rdata.valid;
      if (valid_reg)
      begin
        hold_reg  <= compare_reg;
        beat_seen <= 1'b1;
        // sticky until reset
        if (!(&compare_reg))
          fail_seen <= 1'b1;
      end
    end
  end

  // output register stages
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      for (int s = 0; s < OUT_STAGES; s++)
      begin
        pnf_pipe[s]     <= '1;
        persist_pipe[s] <= 1'b0;
      end
    end
    else
    begin
      pnf_pipe[0]     <= hold_reg;
      persist_pipe[0] <= beat_seen & ~fail_seen;
      for (int s = 1; s < OUT_STAGES; s++)
      begin
        pnf_pipe[s]     <= pnf_pipe[s-1];
        persist_pipe[s] <= persist_pipe[s-1];
      end
    end
  end

  assign pnf_per_byte = pnf_pipe[OUT_STAGES-1];
  assign pnf_persist  = persist_pipe[OUT_STAGES-1];

endmodule

/* traffic_driver.sv */
// Memory traffic driver top level
module traffic_driver (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        local_ready,
  input  mem_local_pkg::local_rdata_t rdata,
  output mem_local_pkg::local_cmd_t   cmd,
  output mem_local_pkg::local_data_t  wdata,
  output mem_local_pkg::lane_mask_t   pnf_per_byte,
  output logic                        pnf_persist,
  output logic                        test_complete
);

  import mem_local_pkg::*;
  import traffic_pkg::*;

  local_cmd_t cmd_req;
  gen_ctrl_t  gen;
  mem_addr_t  addr;
  logic       addr_last;

  // request fields from the FSM, address from the counter
  assign cmd = '{write_req:  cmd_req.write_req,
                 read_req:   cmd_req.read_req,
                 burstbegin: cmd_req.burstbegin,
                 size:       cmd_req.size,
                 bank:       addr.bank,
                 row:        addr.row,
                 col:        addr.col};

  traffic_ctrl u_ctrl (
    .clk           (clk),
    .reset_n       (reset_n),
    .local_ready   (local_ready),
    .rdata_valid   (rdata.valid),
    .addr_last     (addr_last),
    .cmd_req       (cmd_req),
    .gen           (gen),
    .test_complete (test_complete)
  );

  addr_gen u_addr (
    .clk        (clk),
    .reset_n    (reset_n),
    .addr_reset (gen.addr_reset),
    .addr_step  (gen.addr_step),
    .addr       (addr),
    .addr_last  (addr_last)
  );

  // same word serves as write data and as the expected read data
  data_gen u_dgen (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (gen.dgen_load),
    .advance (gen.dgen_advance_wr),
    .data    (wdata)
  );

  data_checker u_check (
    .clk          (clk),
    .reset_n      (reset_n),
    .expected     (wdata),
    .rdata        (rdata),
    .pnf_per_byte (pnf_per_byte),
    .pnf_persist  (pnf_persist)
  );

endmodule

/* tb_local_mem.sv */
// Local port memory model
`include "traffic_settings.svh"

module tb_local_mem (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        stall_en,
  input  logic                        fault_en,
  input  logic [7:0]                  fault_beat,
  input  logic [1:0]                  fault_lane,
  input  mem_local_pkg::local_cmd_t   cmd,
  input  mem_local_pkg::local_data_t  wdata,
  output logic                        local_ready,
  output mem_local_pkg::local_rdata_t rdata,
  output logic                        fault_hit
);

  timeunit 1ns;
  timeprecision 100ps;

  import mem_local_pkg::*;

  // storage keyed by burst address times burst length plus beat
  local_data_t mem [int];
  int          wr_addr_log [$];
  local_data_t wr_data_log [$];
  int          rd_addr_log [$];
  int          rd_beats;
  local_data_t rq_data [$];
  longint      rq_due [$];
  longint      cyc;
  longint      last_due;
  longint      due;
  int          wr_beat;
  int          fault_cnt;
  int          lat;
  int          key;
  logic        ready_next;

  function automatic int addr_key(local_cmd_t c);
    return int'({c.bank, c.row, c.col});
  endfunction

  initial
  begin
    local_ready = 1'b0;
    rdata       = '0;
    fault_hit   = 1'b0;
  end

  // ready, accepts and read returns all change on the falling edge
  always @(negedge clk)
  begin
    if (!reset_n)
    begin
      mem.delete();
      wr_addr_log.delete();
      wr_data_log.delete();
      rd_addr_log.delete();
      rq_data.delete();
      rq_due.delete();
      rd_beats    = 0;
      cyc         = 0;
      last_due    = 0;
      wr_beat     = 0;
      fault_cnt   = 0;
      local_ready = 1'b0;
      rdata       = '0;
      fault_hit   = 1'b0;
    end
    else
    begin
      cyc++;
      ready_next  = !stall_en || ($urandom_range(3) != 0);
      local_ready = ready_next;
      if (cmd.write_req && ready_next)
      begin
        if (cmd.burstbegin)
        begin
          wr_beat = 0;
          wr_addr_log.push_back(addr_key(cmd));
        end
        mem[addr_key(cmd) * `TD_BURST_LEN + wr_beat] = wdata;
        wr_data_log.push_back(wdata);
        wr_beat++;
      end
      // beats of one command return in order after a random latency
      if (cmd.read_req && cmd.burstbegin && ready_next)
      begin
        rd_addr_log.push_back(addr_key(cmd));
        lat = $urandom_range(6, 1);
        for (int b = 0; b < `TD_BURST_LEN; b++)
        begin
          key = addr_key(cmd) * `TD_BURST_LEN + b;
          due = cyc + lat + b;
          if (due <= last_due)
            due = last_due + 1;
          last_due = due;
          rq_due.push_back(due);
          rq_data.push_back(mem.exists(key) ? mem[key] : '0);
        end
      end
      rdata     = '0;
      fault_hit = 1'b0;
      if (rq_due.size() > 0 && rq_due[0] <= cyc)
      begin
        rdata.valid = 1'b1;
        rdata.data  = rq_data.pop_front();
        void'(rq_due.pop_front());
        rd_beats++;
        if (fault_en)
        begin
          if (fault_cnt == fault_beat)
          begin
            rdata.data[8*fault_lane +: 8] = rdata.data[8*fault_lane +: 8] ^ 8'hff;
            fault_hit = 1'b1;
          end
          fault_cnt++;
        end
      end
      if (!fault_en)
        fault_cnt = 0;
    end
  end

endmodule

/* tb_traffic_driver.sv */
// Traffic driver testbench
`include "traffic_settings.svh"

module tb_traffic_driver;

  timeunit 1ns;
  timeprecision 100ps;

  import mem_local_pkg::*;

  localparam int NCOL       = `TD_COL_MAX / `TD_COL_STEP + 1;
  localparam int BURSTS     = NCOL * (`TD_ROW_MAX + 1) * (`TD_BANK_MAX + 1);
  localparam int BEATS      = BURSTS * `TD_BURST_LEN;
  localparam int NUM_PASSES = 6;
  localparam int TIMEOUT_NS = 4 * NUM_PASSES * BURSTS * `TD_BURST_LEN * 12 * 4;
  localparam int FAULT_BEAT = 5;
  localparam int FAULT_LANE = 2;

  logic         clk = 1'b0;
  logic         reset_n;
  logic         local_ready;
  local_rdata_t rdata;
  local_cmd_t   cmd;
  local_data_t  wdata;
  lane_mask_t   pnf_per_byte;
  logic         pnf_persist;
  logic         test_complete;
  logic         stall_en;
  logic         fault_en;
  logic [7:0]   fault_beat;
  logic [1:0]   fault_lane;
  logic         fault_hit;
  local_data_t  snap [int];

  always #2 clk = ~clk;

  traffic_driver DUT (
    .clk           (clk),
    .reset_n       (reset_n),
    .local_ready   (local_ready),
    .rdata         (rdata),
    .cmd           (cmd),
    .wdata         (wdata),
    .pnf_per_byte  (pnf_per_byte),
    .pnf_persist   (pnf_persist),
    .test_complete (test_complete)
  );

  tb_local_mem u_mem (
    .clk         (clk),
    .reset_n     (reset_n),
    .stall_en    (stall_en),
    .fault_en    (fault_en),
    .fault_beat  (fault_beat),
    .fault_lane  (fault_lane),
    .cmd         (cmd),
    .wdata       (wdata),
    .local_ready (local_ready),
    .rdata       (rdata),
    .fault_hit   (fault_hit)
  );

  // ----------------------------------------------------------
  // reference models
  // ----------------------------------------------------------
  function automatic logic [7:0] lfsr_step(logic [7:0] x);
    return {x[6:0], x[7] ^ x[5] ^ x[4] ^ x[3]};
  endfunction

  function automatic local_data_t expected_word(int beat);
    local_data_t w;
    logic [7:0]  x;
    for (int n = 0; n < `TD_LANES; n++)
    begin
      x = 8'(`TD_SEED_BASE + n * `TD_SEED_STEP);
      if (x == 8'd0)
        x = 8'd1;
      for (int s = 0; s < beat; s++)
        x = lfsr_step(x);
      w[8*n +: 8] = x;
    end
    return w;
  endfunction

  // column innermost, then row, then bank; packed as bank, row, col
  function automatic int expected_addr(int b);
    int col;
    int row;
    int bank;
    col  = (b % NCOL) * `TD_COL_STEP;
    row  = (b / NCOL) % (`TD_ROW_MAX + 1);
    bank = b / (NCOL * (`TD_ROW_MAX + 1));
    return (bank << 24) | (row << 10) | col;
  endfunction

  // ----------------------------------------------------------
  // helpers
  // ----------------------------------------------------------
  task automatic fail_run(string msg);
    $display("%s", msg);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    assert (got === exp)
    else
      fail_run($sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic apply_reset();
    reset_n = 1'b0;
    repeat (3) @(negedge clk);
    reset_n = 1'b1;
  endtask

  task automatic wait_complete();
    do
      @(negedge clk);
    while (!test_complete);
  endtask

  task automatic check_read_pass(int pass);
    for (int b = 0; b < BURSTS; b++)
      check_value("read address", u_mem.rd_addr_log[pass*BURSTS + b], expected_addr(b));
    check_value("read beats", u_mem.rd_beats, (pass + 1) * BEATS);
    check_value("pnf_persist", pnf_persist, 1);
    check_value("pnf_per_byte", pnf_per_byte, {`TD_LANES{1'b1}});
  endtask

  // ----------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------
  task automatic test_reset_state();
    apply_reset();
    @(negedge clk);
    check_value("write_req", cmd.write_req, 0);
    check_value("read_req", cmd.read_req, 0);
    check_value("burstbegin", cmd.burstbegin, 0);
    check_value("test_complete", test_complete, 0);
    check_value("pnf_persist", pnf_persist, 0);
    check_value("pnf_per_byte", pnf_per_byte, {`TD_LANES{1'b1}});
    @(negedge clk);
    check_value("write_req", cmd.write_req, 1);
    check_value("burstbegin", cmd.burstbegin, 1);
    check_value("size", cmd.size, `TD_BURST_LEN);
  endtask

  task automatic test_write_pass();
    wait_complete();
    check_value("write bursts", u_mem.wr_addr_log.size(), BURSTS);
    for (int b = 0; b < BURSTS; b++)
      check_value("write address", u_mem.wr_addr_log[b], expected_addr(b));
    check_value("write beats", u_mem.wr_data_log.size(), BEATS);
    for (int j = 0; j < BEATS; j++)
      check_value("wdata", u_mem.wr_data_log[j], expected_word(j));
    check_value("stored beats", u_mem.mem.size(), BEATS);
  endtask

  task automatic test_clean_readback();
    check_read_pass(0);
    snap = u_mem.mem;
    @(negedge clk);
    check_value("test_complete", test_complete, 0);
    wait_complete();
    check_read_pass(1);
    for (int j = 0; j < BEATS; j++)
      check_value("wdata", u_mem.wr_data_log[BEATS + j], expected_word(j));
  endtask

  task automatic test_backpressure();
    stall_en = 1'b1;
    apply_reset();
    wait_complete();
    check_value("stored beats", u_mem.mem.size(), snap.size());
    foreach (snap[k])
    begin
      assert (u_mem.mem.exists(k))
      else
        fail_run($sformatf("stored beat at key 0x%0h is missing", k));
      check_value("memory word", u_mem.mem[k], snap[k]);
    end
    check_value("read commands", u_mem.rd_addr_log.size(), BURSTS);
    check_value("read beats", u_mem.rd_beats, u_mem.rd_addr_log.size() * `TD_BURST_LEN);
    check_value("pnf_persist", pnf_persist, 1);
  endtask

  task automatic test_fault_detect();
    lane_mask_t exp_mask;
    exp_mask             = '1;
    exp_mask[FAULT_LANE] = 1'b0;
    fault_beat = 8'(FAULT_BEAT);
    fault_lane = 2'(FAULT_LANE);
    fault_en   = 1'b1;
    do
      @(posedge clk);
    while (!fault_hit);
    @(posedge clk);
    @(negedge clk);
    check_value("pnf_per_byte", pnf_per_byte, {`TD_LANES{1'b1}});
    @(posedge clk);
    @(negedge clk);
    check_value("pnf_per_byte", pnf_per_byte, exp_mask);
    check_value("pnf_persist", pnf_persist, 0);
    // the flag stays down through the clean passes that follow
    repeat (3)
    begin
      wait_complete();
      check_value("pnf_persist", pnf_persist, 0);
    end
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    fail_run("timeout: the tests did not finish in time");
  end

  initial
  begin
    void'($urandom(32'hec049a01));
    reset_n    = 1'b0;
    stall_en   = 1'b0;
    fault_en   = 1'b0;
    fault_beat = 8'd0;
    fault_lane = 2'd0;
    test_reset_state();
    test_write_pass();
    test_clean_readback();
    test_backpressure();
    test_fault_detect();
    $display(">>> PASS");
    $finish;
  end

endmodule

/* list.f */
+incdir+.
mem_local_pkg.sv
traffic_pkg.sv
lfsr8.sv
data_gen.sv
addr_gen.sv
traffic_ctrl.sv
data_checker.sv
traffic_driver.sv
tb_local_mem.sv
tb_traffic_driver.sv

/* Bender.yml */
package:
  name: traffic_driver

sources:
  - include_dirs:
      - .
    files:
      - mem_local_pkg.sv
      - traffic_pkg.sv
      - lfsr8.sv
      - data_gen.sv
      - addr_gen.sv
      - traffic_ctrl.sv
      - data_checker.sv
      - traffic_driver.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_local_mem.sv
      - tb_traffic_driver.sv
